/* Bender.yml */
package:
  name: io_top

sources:
  - hw/io_regs_pkg.sv
  - hw/serial_pkg.sv
  - hw/baud_gen.sv
  - hw/uart_tx.sv
  - hw/uart_rx.sv
  - hw/port_unit.sv
  - hw/io_reg_decode.sv
  - hw/io_top.sv
  - target: test
    files:
      - verif/tb_io_top.sv

/* files.f */
hw/io_regs_pkg.sv
hw/serial_pkg.sv
hw/baud_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/port_unit.sv
hw/io_reg_decode.sv
hw/io_top.sv
verif/tb_io_top.sv

/* hw/baud_gen.sv */
////////////////////
// Baud tick source
////////////////////

`timescale 1ns/1ps

module baud_gen
(
	input MCLK,
	input reset_i,
	output logic [serial_pkg::NUM_RATES-1:0] tick_o
);
	import serial_pkg::*;

	logic [$clog2(PRESCALE)-1:0] pre_cnt;
	logic [NUM_RATES-2:0] div_cnt;
	logic base_tick;
	logic [NUM_RATES-1:0] carry;

	assign base_tick = (pre_cnt == PRESCALE - 1);

	// Each divider stage passes the carry on when it is all ones.
	always_comb
	begin
		carry[0] = base_tick;
		for (int n = 1; n < NUM_RATES; n++)
			carry[n] = carry[n-1] & div_cnt[n-1];
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			pre_cnt <= '0;
			div_cnt <= '0;
			tick_o <= '0;
		end
		else
		begin
			tick_o <= carry; // One-cycle pulses.
			if (base_tick)
			begin
				pre_cnt <= '0;
				div_cnt <= div_cnt + 1'b1;
			end
			else
				pre_cnt <= pre_cnt + 1'b1;
		end
	end

endmodule

/* hw/io_reg_decode.sv */
////////////////////
// Register decode
////////////////////

`timescale 1ns/1ps

module io_reg_decode
(
	input MCLK,
	input reset_i,
	input [io_regs_pkg::ADDR_W-1:0] addr_i,
	input wr_i,
	input rd_i,
	input [io_regs_pkg::NUM_PORTS-1:0][io_regs_pkg::DATA_W-1:0] data_img_i,
	input [io_regs_pkg::NUM_PORTS-1:0][io_regs_pkg::DATA_W-1:0] ctrl_img_i,
	input [io_regs_pkg::NUM_PORTS-1:0][io_regs_pkg::DATA_W-1:0] tx_img_i,
	input [io_regs_pkg::NUM_PORTS-1:0][io_regs_pkg::DATA_W-1:0] rx_img_i,
	input [io_regs_pkg::NUM_PORTS-1:0][io_regs_pkg::DATA_W-1:0] status_img_i,
	output logic [io_regs_pkg::NUM_PORTS-1:0] wr_data_o,
	output logic [io_regs_pkg::NUM_PORTS-1:0] wr_ctrl_o,
	output logic [io_regs_pkg::NUM_PORTS-1:0] wr_tx_o,
	output logic [io_regs_pkg::NUM_PORTS-1:0] wr_sctrl_o,
	output logic [io_regs_pkg::NUM_PORTS-1:0] rd_rx_o,
	output logic [io_regs_pkg::DATA_W-1:0] rdata_o
);
	import io_regs_pkg::*;

	reg_addr_e reg_addr;
	logic [2**ADDR_W-1:0] sel;
	logic [DATA_W-1:0] read_img;

	assign reg_addr = reg_addr_e'(addr_i);
	assign sel = {{(2**ADDR_W-1){1'b0}}, 1'b1} << reg_addr; // One-hot address.

	assign wr_data_o = {NUM_PORTS{wr_i}} & {sel[DATA_C], sel[DATA_B], sel[DATA_A]};
	assign wr_ctrl_o = {NUM_PORTS{wr_i}} & {sel[CTRL_C], sel[CTRL_B], sel[CTRL_A]};
	assign wr_tx_o = {NUM_PORTS{wr_i}} & {sel[TX_C], sel[TX_B], sel[TX_A]};
	assign wr_sctrl_o = {NUM_PORTS{wr_i}} & {sel[SCTRL_C], sel[SCTRL_B], sel[SCTRL_A]};
	assign rd_rx_o = {NUM_PORTS{rd_i}} & {sel[RX_C], sel[RX_B], sel[RX_A]};

	always_comb
	begin
		case (reg_addr)
			DATA_A: read_img = data_img_i[0];
			DATA_B: read_img = data_img_i[1];
			DATA_C: read_img = data_img_i[2];
			CTRL_A: read_img = ctrl_img_i[0];
			CTRL_B: read_img = ctrl_img_i[1];
			CTRL_C: read_img = ctrl_img_i[2];
			TX_A: read_img = tx_img_i[0];
			RX_A: read_img = rx_img_i[0];
			SCTRL_A: read_img = status_img_i[0];
			TX_B: read_img = tx_img_i[1];
			RX_B: read_img = rx_img_i[1];
			SCTRL_B: read_img = status_img_i[1];
			TX_C: read_img = tx_img_i[2];
			RX_C: read_img = rx_img_i[2];
			SCTRL_C: read_img = status_img_i[2];
			default: read_img = '0; // Address 0 reads zero.
		endcase
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			rdata_o <= '0;
		else if (rd_i)
			rdata_o <= read_img; // Held until the next read.
	end

endmodule

/* hw/io_regs_pkg.sv */
////////////////////
// I/O register map
////////////////////

package io_regs_pkg;

	localparam int DATA_W = 8;
	localparam int ADDR_W = 4;
	localparam int PIN_W = 7;
	localparam int NUM_PORTS = 3;

	typedef enum logic [ADDR_W-1:0] {
		NONE    = 4'h0,
		DATA_A  = 4'h1,
		DATA_B  = 4'h2,
		DATA_C  = 4'h3,
		CTRL_A  = 4'h4,
		CTRL_B  = 4'h5,
		CTRL_C  = 4'h6,
		TX_A    = 4'h7,
		RX_A    = 4'h8,
		SCTRL_A = 4'h9,
		TX_B    = 4'hA,
		RX_B    = 4'hB,
		SCTRL_B = 4'hC,
		TX_C    = 4'hD,
		RX_C    = 4'hE,
		SCTRL_C = 4'hF
	} reg_addr_e;

	localparam int SC_RATE_LO = 6; // Rate select in bits 7:6.
	localparam int SC_RX_EN = 5;
	localparam int SC_TX_EN = 4;
	localparam int SC_RX_IE = 3; // Lowest stored bit.

	localparam int CTRL_IRQ_EN = 7;

	localparam int TX_PIN = 4;
	localparam int RX_PIN = 5;
	localparam int IRQ_PIN = 6;

endpackage

/* hw/io_top.sv */
////////////////////
// Controller I/O chip
////////////////////

`timescale 1ns/1ps

module io_top
(
	input MCLK,
	input reset_i,
	input [io_regs_pkg::ADDR_W-1:0] addr_i,
	input wr_i,
	input rd_i,
	input [io_regs_pkg::DATA_W-1:0] wdata_i,
	input [io_regs_pkg::PIN_W-1:0] port_a_i,
	input [io_regs_pkg::PIN_W-1:0] port_b_i,
	input [io_regs_pkg::PIN_W-1:0] port_c_i,
	output logic [io_regs_pkg::DATA_W-1:0] rdata_o,
	output logic irq_o,
	output logic [io_regs_pkg::PIN_W-1:0] port_a_o,
	output logic [io_regs_pkg::PIN_W-1:0] port_b_o,
	output logic [io_regs_pkg::PIN_W-1:0] port_c_o,
	output logic [io_regs_pkg::PIN_W-1:0] port_a_oe_o,
	output logic [io_regs_pkg::PIN_W-1:0] port_b_oe_o,
	output logic [io_regs_pkg::PIN_W-1:0] port_c_oe_o
);
	import io_regs_pkg::*;
	import serial_pkg::*;

	logic [NUM_RATES-1:0] tick;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_in;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_out;
	logic [NUM_PORTS-1:0][PIN_W-1:0] pin_oe;
	logic [NUM_PORTS-1:0][DATA_W-1:0] data_img;
	logic [NUM_PORTS-1:0][DATA_W-1:0] ctrl_img;
	logic [NUM_PORTS-1:0][DATA_W-1:0] tx_img;
	logic [NUM_PORTS-1:0][DATA_W-1:0] rx_img;
	logic [NUM_PORTS-1:0][DATA_W-1:0] status_img;
	logic [NUM_PORTS-1:0] wr_data;
	logic [NUM_PORTS-1:0] wr_ctrl;
	logic [NUM_PORTS-1:0] wr_tx;
	logic [NUM_PORTS-1:0] wr_sctrl;
	logic [NUM_PORTS-1:0] rd_rx;
	logic [NUM_PORTS-1:0] port_irq;

	assign pin_in = {port_c_i, port_b_i, port_a_i};
	assign port_a_o = pin_out[0];
	assign port_b_o = pin_out[1];
	assign port_c_o = pin_out[2];
	assign port_a_oe_o = pin_oe[0];
	assign port_b_oe_o = pin_oe[1];
	assign port_c_oe_o = pin_oe[2];

	baud_gen u_baud (.MCLK(MCLK), .reset_i(reset_i), .tick_o(tick));

	io_reg_decode u_decode (.MCLK(MCLK), .reset_i(reset_i), .addr_i(addr_i), .wr_i(wr_i),
		.rd_i(rd_i), .data_img_i(data_img), .ctrl_img_i(ctrl_img), .tx_img_i(tx_img),
		.rx_img_i(rx_img), .status_img_i(status_img), .wr_data_o(wr_data),
		.wr_ctrl_o(wr_ctrl), .wr_tx_o(wr_tx), .wr_sctrl_o(wr_sctrl), .rd_rx_o(rd_rx),
		.rdata_o(rdata_o));

	for (genvar p = 0; p < NUM_PORTS; p++)
	begin : g_port
		port_unit u_port (.MCLK(MCLK), .reset_i(reset_i), .pin_i(pin_in[p]), .wdata_i(wdata_i),
			.tick_i(tick), .wr_data_i(wr_data[p]), .wr_ctrl_i(wr_ctrl[p]), .wr_tx_i(wr_tx[p]),
			.wr_sctrl_i(wr_sctrl[p]), .rd_rx_i(rd_rx[p]), .pin_o(pin_out[p]),
			.pin_oe_o(pin_oe[p]), .data_img_o(data_img[p]), .ctrl_img_o(ctrl_img[p]),
			.tx_img_o(tx_img[p]), .rx_img_o(rx_img[p]), .status_img_o(status_img[p]),
			.irq_o(port_irq[p]));
	end

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
			irq_o <= 1'b0;
		else
			irq_o <= |port_irq; // Active high.
	end

endmodule

/* hw/port_unit.sv */
////////////////////
// Controller port
////////////////////

`timescale 1ns/1ps

module port_unit
(
	input MCLK,
	input reset_i,
	input [io_regs_pkg::PIN_W-1:0] pin_i,
	input [io_regs_pkg::DATA_W-1:0] wdata_i,
	input [serial_pkg::NUM_RATES-1:0] tick_i,
	input wr_data_i,
	input wr_ctrl_i,
	input wr_tx_i,
	input wr_sctrl_i,
	input rd_rx_i,
	output logic [io_regs_pkg::PIN_W-1:0] pin_o,
	output logic [io_regs_pkg::PIN_W-1:0] pin_oe_o,
	output logic [io_regs_pkg::DATA_W-1:0] data_img_o,
	output logic [io_regs_pkg::DATA_W-1:0] ctrl_img_o,
	output logic [io_regs_pkg::DATA_W-1:0] tx_img_o,
	output logic [io_regs_pkg::DATA_W-1:0] rx_img_o,
	output logic [io_regs_pkg::DATA_W-1:0] status_img_o,
	output logic irq_o
);
	import io_regs_pkg::*;
	import serial_pkg::*;

	logic [DATA_W-1:0] data_q;
	logic [DATA_W-1:0] ctrl_q;
	logic [DATA_W-1:0] tx_q;
	logic [DATA_W-1:SC_RX_IE] sctrl_q;
	logic [FRAME_DATA_BITS-1:0] rx_data;
	logic rate_tick;
	logic tx_start;
	logic tx_line;
	logic tx_busy;
	logic rx_ready;
	logic rx_error;

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			data_q <= '0;
			ctrl_q <= '0;
			tx_q <= '0;
			sctrl_q <= '0;
		end
		else
		begin
			if (wr_data_i)
				data_q <= wdata_i;
			if (wr_ctrl_i)
				ctrl_q <= wdata_i;
			if (wr_tx_i && !tx_busy)
				tx_q <= wdata_i; // Frame in progress keeps its byte.
			if (wr_sctrl_i)
				sctrl_q <= wdata_i[DATA_W-1:SC_RX_IE];
		end
	end

	assign rate_tick = tick_i[sctrl_q[SC_RATE_LO +: RATE_SEL_W]];
	assign tx_start = wr_tx_i && !tx_busy && sctrl_q[SC_TX_EN];

	uart_tx u_tx (.MCLK(MCLK), .reset_i(reset_i), .tick_i(rate_tick), .start_i(tx_start),
		.data_i(wdata_i), .line_o(tx_line), .busy_o(tx_busy));

	uart_rx u_rx (.MCLK(MCLK), .reset_i(reset_i), .tick_i(rate_tick),
		.enable_i(sctrl_q[SC_RX_EN]), .line_i(pin_i[RX_PIN]), .clear_i(rd_rx_i),
		.data_o(rx_data), .ready_o(rx_ready), .error_o(rx_error));

	always_comb
	begin
		pin_o = data_q[PIN_W-1:0];
		pin_oe_o = ctrl_q[PIN_W-1:0]; // 1 drives the pin.
		if (sctrl_q[SC_TX_EN])
		begin
			pin_o[TX_PIN] = tx_line;
			pin_oe_o[TX_PIN] = 1'b1;
		end
		if (sctrl_q[SC_RX_EN])
			pin_oe_o[RX_PIN] = 1'b0;
	end

	assign data_img_o = {data_q[DATA_W-1], pin_i};
	assign ctrl_img_o = ctrl_q;
	assign tx_img_o = tx_q;
	assign rx_img_o = rx_data;
	assign status_img_o = {sctrl_q, rx_error, rx_ready, tx_busy};

	assign irq_o = (ctrl_q[CTRL_IRQ_EN] & ~pin_i[IRQ_PIN]) | (sctrl_q[SC_RX_IE] & rx_ready);

endmodule

/* hw/serial_pkg.sv */
////////////////////
// Serial format
////////////////////

package serial_pkg;

	// Rate n ticks every PRESCALE * 2**n clocks.
	localparam int PRESCALE = 4;
	localparam int NUM_RATES = 4;
	localparam int RATE_SEL_W = 2;

	localparam int OVERSAMPLE = 16; // Ticks per bit.
	localparam int FRAME_DATA_BITS = 8;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

endpackage

/* hw/uart_rx.sv */
////////////////////
// Serial receiver
////////////////////

`timescale 1ns/1ps

module uart_rx
(
	input MCLK,
	input reset_i,
	input tick_i,
	input enable_i,
	input line_i,
	input clear_i,
	output logic [serial_pkg::FRAME_DATA_BITS-1:0] data_o,
	output logic ready_o,
	output logic error_o
);
	import serial_pkg::*;

	rx_state_e state;
	logic [1:0] sync_q;
	logic line_s;
	logic line_prev;
	logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
	logic [$clog2(FRAME_DATA_BITS)-1:0] bit_cnt;
	logic [FRAME_DATA_BITS-1:0] shift_q;
	logic sample;

	assign line_s = sync_q[1];

	// Mid-bit point of a data or stop bit.
	assign sample = enable_i && tick_i && (tick_cnt == OVERSAMPLE - 1);

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			sync_q <= 2'b11; // Line idles high.
			state <= RX_IDLE;
			line_prev <= 1'b1;
			tick_cnt <= '0;
			bit_cnt <= '0;
			data_o <= '0;
			ready_o <= 1'b0;
			error_o <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], line_i};
			if (clear_i)
			begin
				ready_o <= 1'b0;
				error_o <= 1'b0;
			end
			if (!enable_i)
				state <= RX_IDLE;
			else if (tick_i)
			begin
				line_prev <= line_s;
				tick_cnt <= tick_cnt + 1'b1;
				case (state)
					RX_IDLE:
						if (line_prev && !line_s)
						begin
							state <= RX_START;
							tick_cnt <= '0;
						end
					RX_START:
						if (tick_cnt == OVERSAMPLE / 2 - 1)
						begin
							tick_cnt <= '0;
							bit_cnt <= '0;
							state <= line_s ? RX_IDLE : RX_DATA; // Glitch rejected.
						end
					RX_DATA:
						if (sample)
						begin
							bit_cnt <= bit_cnt + 1'b1;
							if (bit_cnt == FRAME_DATA_BITS - 1)
								state <= RX_STOP;
						end
					RX_STOP:
						if (sample)
						begin
							data_o <= shift_q;
							ready_o <= 1'b1;
							error_o <= ~line_s; // Bad stop bit.
							state <= RX_IDLE;
						end
					default:
						state <= RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (sample && state == RX_DATA)
			shift_q <= {line_s, shift_q[FRAME_DATA_BITS-1:1]};
	end

endmodule

/* hw/uart_tx.sv */
////////////////////
// Serial transmitter
////////////////////

`timescale 1ns/1ps

module uart_tx
(
	input MCLK,
	input reset_i,
	input tick_i,
	input start_i,
	input [serial_pkg::FRAME_DATA_BITS-1:0] data_i,
	output logic line_o,
	output logic busy_o
);
	import serial_pkg::*;

	tx_state_e state;
	logic [$clog2(OVERSAMPLE)-1:0] tick_cnt;
	logic [$clog2(FRAME_DATA_BITS)-1:0] bit_cnt;
	logic [FRAME_DATA_BITS-1:0] shift_q;
	logic bit_end;

	assign bit_end = tick_i && (tick_cnt == OVERSAMPLE - 1);
	assign busy_o = (state != TX_IDLE);

	always_ff @(posedge MCLK)
	begin
		if (reset_i)
		begin
			state <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt <= '0;
		end
		else
		begin
			if (tick_i)
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				TX_IDLE:
					if (start_i)
					begin
						state <= TX_START;
						tick_cnt <= '0;
					end
				TX_START:
					if (bit_end)
					begin
						state <= TX_DATA;
						bit_cnt <= '0;
					end
				TX_DATA:
					if (bit_end)
					begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == FRAME_DATA_BITS - 1)
							state <= TX_STOP;
					end
				TX_STOP:
					if (bit_end)
						state <= TX_IDLE;
				default:
					state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge MCLK)
	begin
		if (state == TX_IDLE && start_i)
			shift_q <= data_i;
		else if (state == TX_DATA && bit_end)
			shift_q <= shift_q >> 1; // LSB first.
	end

	always_comb
	begin
		case (state)
			TX_START: line_o = 1'b0;
			TX_DATA: line_o = shift_q[0];
			default: line_o = 1'b1; // Idle and stop.
		endcase
	end

endmodule

/* verif/tb_io_top.sv */
////////////////////
// I/O chip testbench
////////////////////

`timescale 1ns/1ps

module tb_io_top;
	import io_regs_pkg::*;
	import serial_pkg::*;

	localparam int POLL_LIMIT = 10000;
	localparam int IRQ_LIMIT = 200;

	logic MCLK;
	logic reset_i;
	logic [ADDR_W-1:0] addr_i;
	logic wr_i;
	logic rd_i;
	logic [DATA_W-1:0] wdata_i;
	logic [PIN_W-1:0] port_a_i;
	logic [PIN_W-1:0] port_b_i;
	logic [PIN_W-1:0] port_c_i;
	logic [PIN_W-1:0] pb_drv;
	logic [DATA_W-1:0] rdata_o;
	logic irq_o;
	logic [PIN_W-1:0] port_a_o;
	logic [PIN_W-1:0] port_b_o;
	logic [PIN_W-1:0] port_c_o;
	logic [PIN_W-1:0] port_a_oe_o;
	logic [PIN_W-1:0] port_b_oe_o;
	logic [PIN_W-1:0] port_c_oe_o;

	// Shadow of the register file.
	logic [7:0] data_sh [NUM_PORTS];
	logic [7:0] ctrl_sh [NUM_PORTS];
	logic [7:0] tx_sh [NUM_PORTS];
	logic [7:0] rx_sh [NUM_PORTS];
	logic [7:0] sctrl_sh [NUM_PORTS];
	logic rdy_sh [NUM_PORTS];
	logic err_sh [NUM_PORTS];
	logic busy_sh [NUM_PORTS];

	logic [31:0] lfsr;
	logic [7:0] got_q [$];
	logic [7:0] exp_q [$];
	string name_q [$];
	int mismatches;
	int timeouts;

	assign port_b_i = {pb_drv[6], port_a_o[TX_PIN], pb_drv[4:0]}; // A pin 4 loops to B pin 5.

	io_top DUT (.*);

	initial
	begin
		MCLK = 1'b0;
		forever #4 MCLK = ~MCLK;
	end

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[6:0], fb};
		end
		return v;
	endfunction

	function automatic int port_of(input reg_addr_e addr);
		if (addr == NONE)
			return 0;
		else if (addr <= DATA_C)
			return int'(addr) - 1;
		else if (addr <= CTRL_C)
			return int'(addr) - 4;
		return (int'(addr) - 7) / 3;
	endfunction

	function automatic logic [6:0] ref_pin_out(input int p);
		logic [6:0] v;
		v = data_sh[p][6:0];
		if (sctrl_sh[p][SC_TX_EN])
			v[TX_PIN] = 1'b1; // Line idles high between frames.
		return v;
	endfunction

	function automatic logic [6:0] ref_pin_oe(input int p);
		logic [6:0] v;
		v = ctrl_sh[p][6:0];
		if (sctrl_sh[p][SC_TX_EN])
			v[TX_PIN] = 1'b1;
		if (sctrl_sh[p][SC_RX_EN])
			v[RX_PIN] = 1'b0;
		return v;
	endfunction

	function automatic logic [6:0] ref_pin_in(input int p);
		logic [6:0] a_out;
		logic [6:0] v;
		a_out = ref_pin_out(0);
		case (p)
			0: v = port_a_i;
			1: v = {pb_drv[6], a_out[TX_PIN], pb_drv[4:0]};
			default: v = port_c_i;
		endcase
		return v;
	endfunction

	function automatic logic [7:0] ref_read(input reg_addr_e addr);
		logic [7:0] v;
		int p;
		p = port_of(addr);
		case (addr)
			NONE: v = 8'h00;
			DATA_A, DATA_B, DATA_C: v = {data_sh[p][7], ref_pin_in(p)};
			CTRL_A, CTRL_B, CTRL_C: v = ctrl_sh[p];
			TX_A, TX_B, TX_C: v = tx_sh[p];
			RX_A, RX_B, RX_C: v = rx_sh[p];
			default: v = {sctrl_sh[p][7:3], err_sh[p], rdy_sh[p], busy_sh[p]};
		endcase
		return v;
	endfunction

	function automatic logic ref_irq();
		logic v;
		logic [6:0] pins;
		v = 1'b0;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			pins = ref_pin_in(p);
			v = v | (ctrl_sh[p][CTRL_IRQ_EN] & ~pins[IRQ_PIN]);
			v = v | (sctrl_sh[p][SC_RX_IE] & rdy_sh[p]);
		end
		return v;
	endfunction

	function automatic logic [6:0] dut_pin(input int p, input logic oe);
		case (p)
			0: return oe ? port_a_oe_o : port_a_o;
			1: return oe ? port_b_oe_o : port_b_o;
			default: return oe ? port_c_oe_o : port_c_o;
		endcase
	endfunction

	task automatic expect_value(input string name, input logic [7:0] got,
		input logic [7:0] exp_val);
		name_q.push_back(name);
		got_q.push_back(got);
		exp_q.push_back(exp_val);
	endtask

	task automatic bus_write(input reg_addr_e addr, input logic [7:0] data);
		int p;
		p = port_of(addr);
		@(posedge MCLK);
		addr_i <= addr;
		wdata_i <= data;
		wr_i <= 1'b1;
		@(posedge MCLK);
		wr_i <= 1'b0;
		case (addr)
			DATA_A, DATA_B, DATA_C: data_sh[p] = data;
			CTRL_A, CTRL_B, CTRL_C: ctrl_sh[p] = data;
			TX_A, TX_B, TX_C:
				if (!busy_sh[p])
				begin
					tx_sh[p] = data;
					busy_sh[p] = sctrl_sh[p][SC_TX_EN];
				end
			SCTRL_A, SCTRL_B, SCTRL_C: sctrl_sh[p] = data & 8'hF8;
			default: ;
		endcase
	endtask

	task automatic bus_read(input reg_addr_e addr, output logic [7:0] data);
		@(posedge MCLK);
		addr_i <= addr;
		rd_i <= 1'b1;
		@(posedge MCLK);
		rd_i <= 1'b0;
		@(negedge MCLK);
		data = rdata_o;
	endtask

	task automatic check_read(input reg_addr_e addr);
		logic [7:0] exp_val;
		logic [7:0] got;
		int p;
		exp_val = ref_read(addr);
		p = port_of(addr);
		bus_read(addr, got);
		expect_value(addr.name(), got, exp_val);
		if (addr == RX_A || addr == RX_B || addr == RX_C)
		begin
			rdy_sh[p] = 1'b0; // Read clears both flags.
			err_sh[p] = 1'b0;
		end
	endtask

	task automatic drive_pins(input int p, input logic [6:0] v);
		@(posedge MCLK);
		case (p)
			0: port_a_i <= v;
			1: pb_drv <= v;
			default: port_c_i <= v;
		endcase
	endtask

	task automatic check_pins(input int p);
		@(negedge MCLK);
		expect_value($sformatf("port%0d pin_o", p), {1'b0, dut_pin(p, 1'b0)},
			{1'b0, ref_pin_out(p)});
		expect_value($sformatf("port%0d pin_oe_o", p), {1'b0, dut_pin(p, 1'b1)},
			{1'b0, ref_pin_oe(p)});
	endtask

	// Interrupt output is one register after its source.
	task automatic check_irq();
		@(posedge MCLK);
		@(negedge MCLK);
		expect_value("irq_o", {7'b0, irq_o}, {7'b0, ref_irq()});
	endtask

	task automatic wait_status(input reg_addr_e addr, input logic [7:0] mask,
		input logic [7:0] value, input string what);
		logic [7:0] v;
		logic done;
		int polls;
		done = 1'b0;
		polls = 0;
		while (!done && polls < POLL_LIMIT)
		begin
			bus_read(addr, v);
			done = ((v & mask) == value);
			polls++;
		end
		if (!done)
		begin
			timeouts++;
			$display("Timeout at %0t: %s never happened", $time, what);
		end
	endtask

	task automatic wait_irq(input logic level);
		int cycles;
		cycles = 0;
		while (irq_o !== level && cycles < IRQ_LIMIT)
		begin
			@(negedge MCLK);
			cycles++;
		end
		if (irq_o !== level)
		begin
			timeouts++;
			$display("Timeout at %0t: irq_o did not reach %b", $time, level);
		end
	endtask

	task automatic send_frame_c(input logic [7:0] data, input logic stop_bit, input int rate);
		logic [FRAME_DATA_BITS+1:0] frame;
		int bit_clk;
		frame = {stop_bit, data, 1'b0};
		bit_clk = PRESCALE * (1 << rate) * OVERSAMPLE;
		for (int i = 0; i < FRAME_DATA_BITS + 2; i++)
		begin
			@(posedge MCLK);
			port_c_i[RX_PIN] <= frame[i];
			repeat (bit_clk - 1) @(posedge MCLK);
		end
		@(posedge MCLK);
		port_c_i[RX_PIN] <= 1'b1;
	endtask

	initial
	begin : compare
		logic [7:0] got;
		logic [7:0] exp_val;
		string name;
		forever
		begin
			@(negedge MCLK);
			while (got_q.size() > 0)
			begin
				got = got_q.pop_front();
				exp_val = exp_q.pop_front();
				name = name_q.pop_front();
				assert (got === exp_val)
				else
				begin
					mismatches++;
					$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp_val);
				end
			end
		end
	end

	initial
	begin : main
		reg_addr_e ra;
		logic [7:0] rd_val;
		logic [7:0] rnd;
		int drain;
		mismatches = 0;
		timeouts = 0;
		lfsr = 32'h310;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			data_sh[p] = '0;
			ctrl_sh[p] = '0;
			tx_sh[p] = '0;
			rx_sh[p] = '0;
			sctrl_sh[p] = '0;
			rdy_sh[p] = 1'b0;
			err_sh[p] = 1'b0;
			busy_sh[p] = 1'b0;
		end
		reset_i <= 1'b1;
		addr_i <= '0;
		wr_i <= 1'b0;
		rd_i <= 1'b0;
		wdata_i <= '0;
		port_a_i <= '0;
		pb_drv <= '0;
		port_c_i <= '0;
		repeat (8) @(posedge MCLK);
		reset_i <= 1'b0;

		// Reset state.
		@(negedge MCLK);
		for (int p = 0; p < NUM_PORTS; p++)
			expect_value($sformatf("port%0d pin_oe_o", p), {1'b0, dut_pin(p, 1'b1)}, 8'h00);
		expect_value("irq_o", {7'b0, irq_o}, 8'h00);
		for (int a = 0; a < 16; a++)
		begin
			ra = reg_addr_e'(a);
			bus_read(ra, rd_val);
			expect_value(ra.name(), rd_val, 8'h00);
		end

		// Parallel pins.
		for (int p = 0; p < NUM_PORTS; p++)
			for (int n = 0; n < 4; n++)
			begin
				bus_write(reg_addr_e'(int'(DATA_A) + p), rand_bits(8));
				bus_write(reg_addr_e'(int'(CTRL_A) + p), rand_bits(8));
				rnd = rand_bits(7);
				drive_pins(p, rnd[6:0]);
				check_pins(p);
				check_read(reg_addr_e'(int'(DATA_A) + p));
				check_read(reg_addr_e'(int'(CTRL_A) + p));
			end

		// Loopback from A to B at each rate.
		for (int r = 0; r < NUM_RATES; r++)
		begin
			bus_write(SCTRL_A, {r[1:0], 6'h10});
			repeat (4) @(posedge MCLK);
			bus_write(SCTRL_B, {r[1:0], 6'h20});
			repeat (4) @(posedge MCLK);
			rnd = rand_bits(8);
			bus_write(TX_A, rnd);
			check_read(SCTRL_A);
			bus_write(TX_A, ~rnd); // Frame in progress keeps its byte.
			check_read(TX_A);
			wait_status(SCTRL_B, 8'h02, 8'h02, "port B rx_ready");
			wait_status(SCTRL_A, 8'h01, 8'h00, "port A tx_busy clear");
			busy_sh[0] = 1'b0;
			rx_sh[1] = rnd;
			rdy_sh[1] = 1'b1;
			check_read(SCTRL_A);
			check_read(SCTRL_B);
			check_read(RX_B);
			check_read(SCTRL_B);
		end

		// Bad stop bit on port C.
		drive_pins(2, 7'h7F);
		bus_write(SCTRL_C, 8'h60);
		repeat (4) @(posedge MCLK);
		rnd = rand_bits(8);
		send_frame_c(rnd, 1'b0, 1);
		wait_status(SCTRL_C, 8'h02, 8'h02, "port C rx_ready");
		rx_sh[2] = rnd;
		rdy_sh[2] = 1'b1;
		err_sh[2] = 1'b1;
		check_read(SCTRL_C);
		check_read(RX_C);
		check_read(SCTRL_C);

		// Interrupt sources.
		for (int p = 0; p < NUM_PORTS; p++)
			bus_write(reg_addr_e'(int'(CTRL_A) + p), 8'h00);
		drive_pins(1, 7'h40);
		drive_pins(0, 7'h40);
		check_irq();
		drive_pins(0, 7'h00);
		check_irq();
		bus_write(CTRL_A, 8'h80);
		check_irq();
		drive_pins(0, 7'h40);
		check_irq();
		bus_write(SCTRL_C, 8'h20);
		rnd = rand_bits(8);
		send_frame_c(rnd, 1'b1, 0);
		wait_status(SCTRL_C, 8'h02, 8'h02, "port C rx_ready");
		rx_sh[2] = rnd;
		rdy_sh[2] = 1'b1;
		check_irq();
		bus_write(SCTRL_C, 8'h28);
		wait_irq(1'b1);
		check_irq();
		check_read(RX_C);
		check_irq();

		drain = 0;
		while (got_q.size() > 0 && drain < 10)
		begin
			@(negedge MCLK);
			drain++;
		end
		@(negedge MCLK);
		if (got_q.size() > 0)
		begin
			timeouts++;
			$display("Timeout: compare queue still holds %0d entries", got_q.size());
		end
		$display("Summary: %0d mismatches, %0d timeouts", mismatches, timeouts);
		if (mismatches == 0 && timeouts == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule
